/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_share_tb
RTL_TOP   ?= mem_share_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

RTL_SRCS = common/mem_share_pkg.sv \
           arbiter/encode_one_hot.sv \
           arbiter/rr_arbiter.sv \
           design/mem_port_router.sv \
           design/shared_sram.sv \
           design/mem_share_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation ended without a pass line"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+common $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* arbiter/encode_one_hot.sv */
// one-hot to index encoder

`timescale 1ns/1ps

// parallel prefix OR tree
// 0001 gives 0, 0010 gives 1, 0100 gives 2, 1000 gives 3
// all zero gives 0 with v_o low
module encode_one_hot
  #(parameter int width_p = 4
  , localparam int addr_w_lp = (width_p > 1) ? $clog2(width_p) : 1
  )
  (input  logic [width_p-1:0]   i
  , output logic [addr_w_lp-1:0] addr_o
  , output logic                 v_o
  );

  localparam int levels_lp = $clog2(width_p);
  // pad up to a power of two
  localparam int aligned_w_lp = 1 << levels_lp;

  // per level address and valid
  // a segment keeps its result at the base bit of its slot
  logic [levels_lp:0][aligned_w_lp-1:0] addr;
  logic [levels_lp:0][aligned_w_lp-1:0] v;

  // leaves, padded with zeros on top
  assign v[0]    = aligned_w_lp'(i);
  assign addr[0] = '0;

  for (genvar lvl = 1; lvl <= levels_lp; lvl++)
  begin : g_level
    localparam int seg_cnt_lp = 1 << (levels_lp - lvl);
    localparam int slot_lp    = 1 << lvl;
    localparam int half_lp    = slot_lp >> 1;

    for (genvar seg = 0; seg < seg_cnt_lp; seg++)
    begin : g_seg
      localparam int base_lp = seg * slot_lp;

      // lower and upper half valids
      logic [1:0]     vs;
      logic [lvl-1:0] seg_addr;

      assign vs = {v[lvl-1][base_lp + half_lp], v[lvl-1][base_lp]};

      // rest of the slot stays zero
      assign v[lvl][base_lp +: slot_lp] = slot_lp'(vs[1] | vs[0]);

      if (lvl == 1)
      begin : g_leaf
        assign seg_addr = vs[1];
      end
      else
      begin : g_node
        // upper half set gives the new msb
        // only one half can carry nonzero low bits for one-hot input
        assign seg_addr = {vs[1],
                           addr[lvl-1][base_lp +: lvl-1]
                           | addr[lvl-1][base_lp + half_lp +: lvl-1]};
      end

      assign addr[lvl][base_lp +: slot_lp] = slot_lp'(seg_addr);
    end
  end

  // root of the tree
  assign addr_o = addr[levels_lp][addr_w_lp-1:0];
  assign v_o    = v[levels_lp][0];

endmodule

/* arbiter/rr_arbiter.sv */
// round-robin client arbiter

`timescale 1ns/1ps

`include "mem_share_config.svh"

module rr_arbiter
  (input  logic                        clk_i
  , input  logic                        arst_n_i
  , input  mem_share_pkg::client_mask_t req_v_i
  , output mem_share_pkg::client_mask_t gnt_o
  , output mem_share_pkg::client_id_t   gnt_id_o
  , output logic                        gnt_v_o
  );

  localparam int clients_lp = `MEM_SHARE_CLIENTS;

  // last granted client
  mem_share_pkg::client_id_t last_q;

  // requests rotated so that last+1 sits at bit 0
  mem_share_pkg::client_mask_t req_rot;
  // lowest set bit of the rotated mask
  mem_share_pkg::client_mask_t sel_rot;

  always_comb
  begin
    for (int j = 0; j < clients_lp; j++)
      req_rot[j] = req_v_i[(int'(last_q) + 1 + j) % clients_lp];
  end

  // isolate lowest set bit
  // zero stays zero
  assign sel_rot = req_rot & ~(req_rot - 1'b1);

  // rotate back to client positions
  always_comb
  begin
    gnt_o = '0;
    for (int j = 0; j < clients_lp; j++)
      gnt_o[(int'(last_q) + 1 + j) % clients_lp] = sel_rot[j];
  end

  // grant index for the pointer and the router
  encode_one_hot
    #(.width_p(clients_lp))
    enc_i
    (.i      (gnt_o)
    , .addr_o (gnt_id_o)
    , .v_o    (gnt_v_o)
    );

  // pointer moves only on a real grant
  // starts at the top so client 0 wins first
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      last_q <= mem_share_pkg::client_id_t'(clients_lp - 1);
    else if (gnt_v_o)
      last_q <= gnt_id_o;
  end

endmodule

/* common/mem_share_config.svh */
// shared memory sizing

`ifndef MEM_SHARE_CONFIG_SVH
`define MEM_SHARE_CONFIG_SVH

// number of peer clients on the shared port
// kept a power of two so the round-robin index wraps cleanly
`define MEM_SHARE_CLIENTS 4

// word address width
// 6 bits gives 64 words
`define MEM_SHARE_ADDR_W 6

// one memory word
`define MEM_SHARE_DATA_W 16

// memory depth follows from the address width
`define MEM_SHARE_DEPTH (1 << `MEM_SHARE_ADDR_W)

`endif

/* common/mem_share_pkg.sv */
// shared memory types

`include "mem_share_config.svh"

package mem_share_pkg;

  // one bit per client
  // used for request valids, grants and response valids
  typedef logic [`MEM_SHARE_CLIENTS-1:0] client_mask_t;

  // client index
  typedef logic [$clog2(`MEM_SHARE_CLIENTS)-1:0] client_id_t;

  // word address and data word
  typedef logic [`MEM_SHARE_ADDR_W-1:0] addr_t;
  typedef logic [`MEM_SHARE_DATA_W-1:0] data_t;

  // one client request
  // wdata is ignored for reads
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_s;

  // all client requests side by side
  typedef mem_req_s [`MEM_SHARE_CLIENTS-1:0] mem_req_array_t;

endpackage

/* design/mem_port_router.sv */
// memory port router

`timescale 1ns/1ps

module mem_port_router
  (input  logic                          clk_i
  , input  logic                          arst_n_i
  , input  mem_share_pkg::client_id_t     gnt_id_i
  , input  logic                          gnt_v_i
  , input  mem_share_pkg::mem_req_array_t req_i
  , output logic                          mem_v_o
  , output mem_share_pkg::mem_req_s       mem_req_o
  , output mem_share_pkg::client_mask_t   rsp_v_o
  );

  // response mask for next cycle
  mem_share_pkg::client_mask_t rsp_v_d;
  mem_share_pkg::client_mask_t rsp_v_q;

  // granted request straight to the memory
  // payload is don't care when gnt_v_i is low
  assign mem_req_o = req_i[gnt_id_i];
  assign mem_v_o   = gnt_v_i;

  // only reads get a response
  // one-hot decode of the granted client
  always_comb
  begin
    rsp_v_d = '0;
    if (gnt_v_i && !mem_req_o.we)
      rsp_v_d[gnt_id_i] = 1'b1;
  end

  // lines up with the registered read word in the memory
  // a single cycle pulse since it reloads every edge
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      rsp_v_q <= '0;
    else
      rsp_v_q <= rsp_v_d;
  end

  assign rsp_v_o = rsp_v_q;

endmodule

/* design/mem_share_top.sv */
// shared memory top level

`timescale 1ns/1ps

module mem_share_top
  (input  logic                          clk_i
  , input  logic                          arst_n_i
  , input  mem_share_pkg::client_mask_t   req_v_i
  , input  mem_share_pkg::mem_req_array_t req_i
  , output mem_share_pkg::client_mask_t   gnt_o
  , output mem_share_pkg::client_mask_t   rsp_v_o
  , output mem_share_pkg::data_t          rsp_data_o
  );

  // arbiter to router
  mem_share_pkg::client_id_t gnt_id;
  logic                      gnt_v;

  // router to memory
  logic                      mem_v;
  mem_share_pkg::mem_req_s   mem_req;

  // picks one client per cycle
  rr_arbiter arb_i
    (.clk_i    (clk_i)
    , .arst_n_i (arst_n_i)
    , .req_v_i  (req_v_i)
    , .gnt_o    (gnt_o)
    , .gnt_id_o (gnt_id)
    , .gnt_v_o  (gnt_v)
    );

  // muxes the winner onto the port
  mem_port_router router_i
    (.clk_i     (clk_i)
    , .arst_n_i  (arst_n_i)
    , .gnt_id_i  (gnt_id)
    , .gnt_v_i   (gnt_v)
    , .req_i     (req_i)
    , .mem_v_o   (mem_v)
    , .mem_req_o (mem_req)
    , .rsp_v_o   (rsp_v_o)
    );

  // read data goes out to everyone
  shared_sram sram_i
    (.clk_i     (clk_i)
    , .mem_v_i   (mem_v)
    , .mem_req_i (mem_req)
    , .rdata_o   (rsp_data_o)
    );

endmodule

/* design/shared_sram.sv */
// single-port shared memory

`timescale 1ns/1ps

`include "mem_share_config.svh"

module shared_sram
  (input  logic                    clk_i
  , input  logic                    mem_v_i
  , input  mem_share_pkg::mem_req_s mem_req_i
  , output mem_share_pkg::data_t    rdata_o
  );

  // word array
  mem_share_pkg::data_t mem_q [`MEM_SHARE_DEPTH];

  // read register
  mem_share_pkg::data_t rdata_q;

  // one access per cycle
  // write lands at the grant edge, read word shows up one cycle later
  always_ff @(posedge clk_i)
  begin
    if (mem_v_i)
    begin
      if (mem_req_i.we)
        mem_q[mem_req_i.addr] <= mem_req_i.wdata;
      else
        rdata_q <= mem_q[mem_req_i.addr];
    end
  end

  // shared by all clients
  assign rdata_o = rdata_q;

endmodule

/* dv/mem_share_tb.sv */
// shared memory testbench

`timescale 1ns/1ps

`include "mem_share_config.svh"

module mem_share_tb;

  localparam int n_lp = `MEM_SHARE_CLIENTS;
  localparam int reset_timeout_lp = 64;

  logic                          clk;
  logic                          arst_n;
  mem_share_pkg::client_mask_t   req_v;
  mem_share_pkg::mem_req_array_t req;
  mem_share_pkg::client_mask_t   gnt;
  mem_share_pkg::client_mask_t   rsp_v;
  mem_share_pkg::data_t          rsp_data;

  // stimulus table with one entry per row
  mem_share_pkg::client_mask_t   mask_q [$];
  mem_share_pkg::mem_req_array_t reqs_q [$];

  // reference model state
  mem_share_pkg::data_t          shadow [`MEM_SHARE_DEPTH];
  int                            last_ptr;
  mem_share_pkg::client_mask_t   exp_rsp_v;
  mem_share_pkg::data_t          exp_rsp_data;
  int unsigned                   lcg_state;

  tb_clk_gen clk_gen_i
    (.clk_o    (clk)
    , .arst_n_o (arst_n)
    );

  mem_share_top dut_i
    (.clk_i      (clk)
    , .arst_n_i   (arst_n)
    , .req_v_i    (req_v)
    , .req_i      (req)
    , .gnt_o      (gnt)
    , .rsp_v_o    (rsp_v)
    , .rsp_data_o (rsp_data)
    );

  // lcg step returning the upper half of the state
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic mem_share_pkg::mem_req_s make_req(logic we, int addr, int data);
    mem_share_pkg::mem_req_s r;
    r.we    = we;
    r.addr  = mem_share_pkg::addr_t'(addr);
    r.wdata = mem_share_pkg::data_t'(data);
    return r;
  endfunction

  // preload word built from every address bit
  function automatic mem_share_pkg::data_t fill_word(mem_share_pkg::addr_t a);
    return mem_share_pkg::data_t'({a, ~a, a[3:0]});
  endfunction

  // first requester above the last grant with wraparound
  function automatic mem_share_pkg::client_mask_t rr_pick(mem_share_pkg::client_mask_t mask,
                                                          int last);
    mem_share_pkg::client_mask_t g;
    int                          c;
    g = '0;
    for (int s = 1; s <= n_lp; s++)
    begin
      c = (last + s) % n_lp;
      if (mask[c])
      begin
        g[c] = 1'b1;
        break;
      end
    end
    return g;
  endfunction

  function automatic int onehot_index(mem_share_pkg::client_mask_t mask);
    int idx;
    idx = 0;
    for (int c = 0; c < n_lp; c++)
      if (mask[c])
        idx = c;
    return idx;
  endfunction

  task automatic check_value(string what, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] %0t: %s got %0h expected %0h", $time, what, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  task automatic add_row(mem_share_pkg::client_mask_t mask, mem_share_pkg::mem_req_array_t r);
    mask_q.push_back(mask);
    reqs_q.push_back(r);
  endtask

  task automatic build_table();
    mem_share_pkg::mem_req_array_t r;
    mem_share_pkg::client_mask_t   m;
    int unsigned                   x;
    int unsigned                   y;
    // full contention writes so the grants rotate twice
    for (int row = 0; row < 2 * n_lp; row++)
    begin
      for (int c = 0; c < n_lp; c++)
        r[c] = make_req(1'b1, 40 + c, 'h1000 + row * 16 + c);
      add_row('1, r);
    end
    // preload every word one client at a time
    for (int a = 0; a < `MEM_SHARE_DEPTH; a++)
    begin
      r = '0;
      r[a % n_lp] = make_req(1'b1, a, int'(fill_word(mem_share_pkg::addr_t'(a))));
      add_row(mem_share_pkg::client_mask_t'(1) << (a % n_lp), r);
    end
    // full contention reads
    for (int row = 0; row < n_lp; row++)
    begin
      for (int c = 0; c < n_lp; c++)
        r[c] = make_req(1'b0, row * n_lp + c, 0);
      add_row('1, r);
    end
    // sparse masks skip idle clients
    for (int c = 0; c < n_lp; c++)
      r[c] = make_req(1'b0, 8 + c, 0);
    repeat (3) add_row(4'b0101, r);
    repeat (2) add_row(4'b1010, r);
    repeat (2) add_row(4'b1001, r);
    add_row(4'b0100, r);
    // write by one client and read back by another
    r = '0;
    r[1] = make_req(1'b1, 'h15, 'hbeef);
    add_row(4'b0010, r);
    r[2] = make_req(1'b0, 'h15, 0);
    add_row(4'b0100, r);
    // writer and reader on one address in the same rows
    r[0] = make_req(1'b1, 'h2a, 'h1234);
    r[3] = make_req(1'b0, 'h2a, 0);
    repeat (2) add_row(4'b1001, r);
    // idle rows then contention while the pointer holds
    repeat (2) add_row('0, r);
    add_row('1, r);
    add_row('0, r);
    // mixed random traffic
    for (int row = 0; row < 200; row++)
    begin
      x = lcg_next();
      m = mem_share_pkg::client_mask_t'(x);
      for (int c = 0; c < n_lp; c++)
      begin
        x = lcg_next();
        y = lcg_next();
        r[c] = make_req(x[0], int'(x[15:10]), int'(y));
      end
      add_row(m, r);
    end
    // flush the last response
    add_row('0, r);
  endtask

  // drive one row and check its grant and the previous row's response
  task automatic run_row(int i);
    mem_share_pkg::client_mask_t exp_gnt;
    mem_share_pkg::mem_req_s     win;
    int                          id;
    @(posedge clk);
    #1;
    req_v = mask_q[i];
    req   = reqs_q[i];
    @(negedge clk);
    exp_gnt = rr_pick(mask_q[i], last_ptr);
    check_value($sformatf("row %0d gnt_o", i), 32'(gnt), 32'(exp_gnt));
    check_value($sformatf("row %0d rsp_v_o", i), 32'(rsp_v), 32'(exp_rsp_v));
    if (exp_rsp_v != '0)
      check_value($sformatf("row %0d rsp_data_o", i), 32'(rsp_data), 32'(exp_rsp_data));
    // advance the model past this row's edge
    exp_rsp_v = '0;
    if (exp_gnt != '0)
    begin
      id       = onehot_index(exp_gnt);
      win      = reqs_q[i][id];
      last_ptr = id;
      if (win.we)
        shadow[win.addr] = win.wdata;
      else
      begin
        exp_rsp_v[id] = 1'b1;
        exp_rsp_data  = shadow[win.addr];
      end
    end
  endtask

  initial
  begin
    int waited;
    req_v        = '0;
    req          = '0;
    lcg_state    = 19;
    last_ptr     = n_lp - 1;
    exp_rsp_v    = '0;
    exp_rsp_data = '0;
    build_table();
    waited = 0;
    while (arst_n !== 1'b1)
    begin
      if (waited == reset_timeout_lp)
      begin
        $display("reset was still asserted after %0d cycles", reset_timeout_lp);
        $display("TESTS FAILED");
        $fatal(1, "reset timeout");
      end
      else
      begin
        @(posedge clk);
        waited++;
      end
    end
    // nothing pending straight out of reset
    check_value("rsp_v_o after reset", 32'(rsp_v), 32'd0);
    $display("running %0d rows", mask_q.size());
    for (int i = 0; i < mask_q.size(); i++)
      run_row(i);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* dv/tb_clk_gen.sv */
// testbench clock and reset

`timescale 1ns/1ps

module tb_clk_gen
  #(parameter int half_period_p = 5
  , parameter int reset_cycles_p = 16
  )
  (output logic clk_o
  , output logic arst_n_o
  );

  // free running clock, 10 ns period by default
  initial
  begin
    clk_o = 1'b0;
    forever
      #half_period_p clk_o = ~clk_o;
  end

  // reset held low for a fixed number of rising edges
  // released just after an edge
  initial
  begin
    arst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule

/* files.f */
+incdir+common
common/mem_share_pkg.sv
arbiter/encode_one_hot.sv
arbiter/rr_arbiter.sv
design/mem_port_router.sv
design/shared_sram.sv
design/mem_share_top.sv
dv/tb_clk_gen.sv
dv/mem_share_tb.sv
